// ==== idma_pkg.sv ====
// idma legalizer package
// bus and page widths, address and length types, request, option and burst
// structs and the legalizer state encoding
package idma_pkg;

    // address and length widths of the 32-bit memory bus
    localparam int unsigned AddrWidth     = 32;
    localparam int unsigned LenWidth      = 32;

    // byte offset bits within one bus word
    localparam int unsigned OffsetWidth   = 2;

    // largest page is 4 KiB
    localparam int unsigned PageAddrWidth = 12;

    // log2 of the longest burst in beats (256 beats)
    localparam int unsigned FullBurstLlen = 8;

    // width of the user burst length limit
    localparam int unsigned MaxLlenWidth  = 3;

    // bursts counted per request
    localparam int unsigned BurstCntWidth = 16;

    // byte address
    typedef logic [AddrWidth-1:0]       addr_t;

    // transfer length in bytes
    typedef logic [LenWidth-1:0]        len_t;

    // bytes within one page with one extra bit so a full 4 KiB page fits
    typedef logic [PageAddrWidth:0]     page_len_t;

    // offset inside a page
    typedef logic [PageAddrWidth-1:0]   page_addr_t;

    // bursts per request
    typedef logic [BurstCntWidth-1:0]   burst_cnt_t;

    // log2 of the max burst length in beats
    typedef logic [MaxLlenWidth-1:0]    max_llen_t;

    // per-side options
    typedef struct packed {
        logic      not_bursting;
        logic      reduce_len;
        max_llen_t max_llen;
    } idma_side_opt_t;

    // one-dimensional copy request
    typedef struct packed {
        len_t           length;
        addr_t          src_addr;
        addr_t          dst_addr;
        idma_side_opt_t src_opt;
        idma_side_opt_t dst_opt;
    } idma_req_t;

    // one legal burst that crosses no page on either side
    typedef struct packed {
        addr_t     src_addr;
        addr_t     dst_addr;
        page_len_t len;
        logic      last;
    } idma_burst_t;

    // legalizer states
    typedef enum logic [0:0] {
        LEGALIZER_IDLE = 1'b0,
        LEGALIZER_BUSY = 1'b1
    } legalizer_state_e;

endpackage

// ==== idma_legalizer_page_splitter.sv ====
// page splitter
// bytes left from one side's address up to the next page boundary, where
// the page size follows the side's burst options
`timescale 1ns/100ps

module idma_legalizer_page_splitter (
    // current byte address of this side
    input  idma_pkg::addr_t     addr_i,
    // side issues single beats only
    input  logic                not_bursting_i,
    // use the user limit instead of the full burst length
    input  logic                reduce_len_i,
    // user limit as log2 of beats
    input  idma_pkg::max_llen_t max_llen_i,
    // bytes until the page boundary
    output idma_pkg::page_len_t num_bytes_to_pb_o
);

    // 4 bits hold anything up to PageAddrWidth
    logic [3:0]           burst_addr_width;
    logic [3:0]           page_addr_width;
    idma_pkg::page_len_t  page_size;
    idma_pkg::page_addr_t page_offset;

    // log2 of the page in bytes
    always_comb begin : proc_addr_width
        // bursting page is one full burst of bus words
        burst_addr_width = 4'(idma_pkg::OffsetWidth) +
            (reduce_len_i ? 4'(max_llen_i) : 4'(idma_pkg::FullBurstLlen));
        if (not_bursting_i) begin
            // single beats use a page of one bus word
            page_addr_width = 4'(idma_pkg::OffsetWidth);
        end else if (burst_addr_width > 4'(idma_pkg::PageAddrWidth)) begin
            // never beyond 4 KiB
            page_addr_width = 4'(idma_pkg::PageAddrWidth);
        end else begin
            page_addr_width = burst_addr_width;
        end
    end

    // page size in bytes
    assign page_size = idma_pkg::page_len_t'(1) << page_addr_width;

    // address bits below the page width, picked bit by bit
    // since the slice bound moves with the options
    always_comb begin : proc_page_offset
        page_offset = '0;
        for (int unsigned i = 0; i < idma_pkg::PageAddrWidth; i++) begin
            page_offset[i] = (page_addr_width > i) ? addr_i[i] : 1'b0;
        end
    end

    // distance to the boundary is a whole page when aligned
    assign num_bytes_to_pb_o = page_size - {1'b0, page_offset};

endmodule

// ==== idma_legalizer.sv ====
// transfer legalizer
// captures a copy request and cuts it into bursts that cross no page on
// either side, one burst per cycle until the length is used up
`timescale 1ns/100ps

module idma_legalizer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // request strobe without back-pressure
    input  logic                 req_valid_i,
    input  idma_pkg::idma_req_t  req_i,
    // a request is in progress
    output logic                 busy_o,
    // burst strobe that cannot be stalled
    output logic                 burst_valid_o,
    output idma_pkg::idma_burst_t burst_o
);

    // control state
    idma_pkg::legalizer_state_e state_d;
    idma_pkg::legalizer_state_e state_q;

    // current transfer loaded on accept and advanced each burst
    idma_pkg::addr_t        src_addr_q;
    idma_pkg::addr_t        dst_addr_q;
    idma_pkg::len_t         len_q;
    idma_pkg::idma_side_opt_t src_opt_q;
    idma_pkg::idma_side_opt_t dst_opt_q;

    // splitter results
    idma_pkg::page_len_t src_bytes_to_pb;
    idma_pkg::page_len_t dst_bytes_to_pb;

    // burst selection
    idma_pkg::page_len_t page_min;
    idma_pkg::page_len_t burst_len;
    logic                burst_last;
    logic                burst_valid;

    // request handling
    logic req_nonzero;
    logic accept;

    // page boundaries of both sides
    idma_legalizer_page_splitter i_src_splitter (
        .addr_i            ( src_addr_q            ),
        .not_bursting_i    ( src_opt_q.not_bursting ),
        .reduce_len_i      ( src_opt_q.reduce_len   ),
        .max_llen_i        ( src_opt_q.max_llen     ),
        .num_bytes_to_pb_o ( src_bytes_to_pb       )
    );

    idma_legalizer_page_splitter i_dst_splitter (
        .addr_i            ( dst_addr_q            ),
        .not_bursting_i    ( dst_opt_q.not_bursting ),
        .reduce_len_i      ( dst_opt_q.reduce_len   ),
        .max_llen_i        ( dst_opt_q.max_llen     ),
        .num_bytes_to_pb_o ( dst_bytes_to_pb       )
    );

    // one burst in every busy cycle
    assign burst_valid = (state_q == idma_pkg::LEGALIZER_BUSY);

    // burst length is the smallest of the two page limits and what is left
    always_comb begin : proc_burst_len
        // tighter of the two pages
        if (src_bytes_to_pb < dst_bytes_to_pb) begin
            page_min = src_bytes_to_pb;
        end else begin
            page_min = dst_bytes_to_pb;
        end
        // remaining length fits inside the page, so this is the final burst
        if (len_q <= idma_pkg::len_t'(page_min)) begin
            burst_len  = idma_pkg::page_len_t'(len_q);
            burst_last = burst_valid;
        end else begin
            burst_len  = page_min;
            burst_last = 1'b0;
        end
    end

    // zero-length requests are dropped
    assign req_nonzero = (req_i.length != '0);

    // state machine
    always_comb begin : proc_fsm
        state_d = state_q;
        accept  = 1'b0;
        case (state_q)
            idma_pkg::LEGALIZER_IDLE: begin
                if (req_valid_i && req_nonzero) begin
                    accept  = 1'b1;
                    state_d = idma_pkg::LEGALIZER_BUSY;
                end
            end
            idma_pkg::LEGALIZER_BUSY: begin
                // the edge ending the last burst can already take the next request
                if (burst_last) begin
                    if (req_valid_i && req_nonzero) begin
                        accept = 1'b1;
                    end else begin
                        state_d = idma_pkg::LEGALIZER_IDLE;
                    end
                end
            end
            default: begin
                state_d = idma_pkg::LEGALIZER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_state
        if (!rst_n_i) begin
            state_q <= idma_pkg::LEGALIZER_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // transfer registers
    always_ff @(posedge clk_i) begin : proc_transfer
        if (accept) begin
            // capture a fresh request
            src_addr_q <= req_i.src_addr;
            dst_addr_q <= req_i.dst_addr;
            len_q      <= req_i.length;
            src_opt_q  <= req_i.src_opt;
            dst_opt_q  <= req_i.dst_opt;
        end else if (burst_valid) begin
            // step past the burst just emitted
            src_addr_q <= src_addr_q + idma_pkg::addr_t'(burst_len);
            dst_addr_q <= dst_addr_q + idma_pkg::addr_t'(burst_len);
            len_q      <= len_q - idma_pkg::len_t'(burst_len);
        end
    end

    // outputs
    assign busy_o         = burst_valid;
    assign burst_valid_o  = burst_valid;
    assign burst_o.src_addr = src_addr_q;
    assign burst_o.dst_addr = dst_addr_q;
    assign burst_o.len      = burst_len;
    assign burst_o.last     = burst_last;

endmodule

// ==== idma_transfer_tracker.sv ====
// transfer tracker
// counts the bursts of the request in progress and strobes completion
// with the final count one cycle after the last burst
`timescale 1ns/100ps

module idma_transfer_tracker (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // burst strobe and its last flag
    input  logic                 burst_valid_i,
    input  logic                 burst_last_i,
    // completion strobe
    output logic                 done_o,
    // bursts of the finished request valid with done_o
    output idma_pkg::burst_cnt_t num_bursts_o
);

    // running count of the current request
    idma_pkg::burst_cnt_t cnt_q;
    // count including the burst seen this cycle
    idma_pkg::burst_cnt_t cnt_inc;
    // final count held for the done strobe
    idma_pkg::burst_cnt_t num_bursts_q;
    logic                 done_q;

    assign cnt_inc = cnt_q + idma_pkg::burst_cnt_t'(1);

    // running counter cleared once the request is complete
    always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_count
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (burst_valid_i) begin
            if (burst_last_i) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_inc;
            end
        end
    end

    // single-cycle completion pulse
    always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_done
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= burst_valid_i & burst_last_i;
        end
    end

    // final count only looked at while done is high
    always_ff @(posedge clk_i) begin : proc_num_bursts
        if (burst_valid_i && burst_last_i) begin
            num_bursts_q <= cnt_inc;
        end
    end

    assign done_o       = done_q;
    assign num_bursts_o = num_bursts_q;

endmodule

// ==== idma_legalizer_top.sv ====
// legalizer top level
// connects the transfer legalizer and the burst tracker to the ports
`timescale 1ns/100ps

module idma_legalizer_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // request strobe and payload
    input  logic                  req_valid_i,
    input  idma_pkg::idma_req_t   req_i,
    // request in progress
    output logic                  busy_o,
    // legal bursts
    output logic                  burst_valid_o,
    output idma_pkg::idma_burst_t burst_o,
    // completion with burst count
    output logic                  done_o,
    output idma_pkg::burst_cnt_t  num_bursts_o
);

    // burst path shared by the outputs and the tracker
    logic                  burst_valid;
    idma_pkg::idma_burst_t burst;

    // request splitting
    idma_legalizer i_legalizer (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .req_valid_i   ( req_valid_i ),
        .req_i         ( req_i       ),
        .busy_o        ( busy_o      ),
        .burst_valid_o ( burst_valid ),
        .burst_o       ( burst       )
    );

    // completion only needs the last flag
    idma_transfer_tracker i_tracker (
        .clk_i         ( clk_i        ),
        .rst_n_i       ( rst_n_i      ),
        .burst_valid_i ( burst_valid  ),
        .burst_last_i  ( burst.last   ),
        .done_o        ( done_o       ),
        .num_bursts_o  ( num_bursts_o )
    );

    assign burst_valid_o = burst_valid;
    assign burst_o       = burst;

endmodule

// ==== tb_idma_legalizer_top.sv ====
// testbench for the legalizer top level
// runs directed requests from the tests file and random requests against a
// page split model, checking every burst and every completion
`timescale 1ns/100ps

module tb_idma_legalizer_top;

    localparam int unsigned TIMEOUT = 2000;
    localparam logic [31:0] SEED    = 32'h459b_96d9;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  req_valid_i;
    idma_pkg::idma_req_t   req_i;
    logic                  busy_o;
    logic                  burst_valid_o;
    idma_pkg::idma_burst_t burst_o;
    logic                  done_o;
    idma_pkg::burst_cnt_t  num_bursts_o;

    // predicted bursts of the request in flight
    idma_pkg::idma_burst_t exp_q[$];

    int unsigned checks;
    int unsigned errors;
    int unsigned timeouts;
    bit          timed_out;

    idma_legalizer_top i_dut (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .req_valid_i   ( req_valid_i   ),
        .req_i         ( req_i         ),
        .busy_o        ( busy_o        ),
        .burst_valid_o ( burst_valid_o ),
        .burst_o       ( burst_o       ),
        .done_o        ( done_o        ),
        .num_bursts_o  ( num_bursts_o  )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // outputs are settled and inputs change 1 ns after the edge
    task automatic step_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input idma_pkg::burst_cnt_t got,
                               input idma_pkg::burst_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_burst(input string name, input idma_pkg::idma_burst_t got,
                               input idma_pkg::idma_burst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got src %h dst %h len %h last %h", name,
                     got.src_addr, got.dst_addr, got.len, got.last);
            $display("    expected src %h dst %h len %h last %h",
                     exp.src_addr, exp.dst_addr, exp.len, exp.last);
        end
    endtask

    // bytes up to the next page boundary of one side
    function automatic int unsigned page_bytes(input idma_pkg::addr_t addr,
                                               input idma_pkg::idma_side_opt_t opt);
        int unsigned width;
        int unsigned page;
        if (opt.not_bursting) begin
            width = idma_pkg::OffsetWidth;
        end else if (opt.reduce_len) begin
            width = idma_pkg::OffsetWidth + opt.max_llen;
        end else begin
            width = idma_pkg::OffsetWidth + 8;
        end
        // 4 KiB cap
        if (width > idma_pkg::PageAddrWidth) begin
            width = idma_pkg::PageAddrWidth;
        end
        page = 1 << width;
        return page - (addr % page);
    endfunction

    // each burst takes the smallest of remaining length and both page limits
    task automatic predict_bursts(input idma_pkg::idma_req_t req);
        idma_pkg::addr_t       src;
        idma_pkg::addr_t       dst;
        idma_pkg::len_t        rem;
        int unsigned           lim;
        idma_pkg::idma_burst_t b;
        exp_q.delete();
        src = req.src_addr;
        dst = req.dst_addr;
        rem = req.length;
        while (rem != 0) begin
            lim = page_bytes(src, req.src_opt);
            if (page_bytes(dst, req.dst_opt) < lim) begin
                lim = page_bytes(dst, req.dst_opt);
            end
            if (rem <= lim) begin
                lim = rem;
            end
            b.src_addr = src;
            b.dst_addr = dst;
            b.len      = idma_pkg::page_len_t'(lim);
            b.last     = (lim == rem);
            exp_q.push_back(b);
            src = src + lim;
            dst = dst + lim;
            rem = rem - lim;
        end
    endtask

    task automatic wait_idle();
        int unsigned cycles;
        cycles = 0;
        while (busy_o !== 1'b0 && cycles < TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        if (busy_o !== 1'b0) begin
            $display("timeout: busy_o did not drop within %0d cycles", TIMEOUT);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_done(output int unsigned cycles);
        cycles = 0;
        while (done_o !== 1'b1 && cycles < TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        if (done_o !== 1'b1) begin
            $display("timeout: done_o never came within %0d cycles", TIMEOUT);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    // issue one request and follow it burst by burst to its completion
    task automatic run_request(input idma_pkg::idma_req_t req,
                               input idma_pkg::burst_cnt_t file_cnt, input bit use_file);
        idma_pkg::burst_cnt_t n;
        idma_pkg::idma_req_t  junk;
        int unsigned          latency;
        predict_bursts(req);
        n = idma_pkg::burst_cnt_t'(exp_q.size());
        wait_idle();
        if (timed_out) begin
            return;
        end
        req_valid_i = 1'b1;
        req_i       = req;
        step_cycle();
        req_valid_i = 1'b0;
        req_i       = '0;
        // zero length must stay silent
        if (n == 0) begin
            repeat (3) begin
                check_bit("burst_valid_o", burst_valid_o, 1'b0);
                check_bit("busy_o", busy_o, 1'b0);
                check_bit("done_o", done_o, 1'b0);
                step_cycle();
            end
            return;
        end
        for (int i = 0; i < n; i++) begin
            check_bit("burst_valid_o", burst_valid_o, 1'b1);
            check_bit("busy_o", busy_o, 1'b1);
            check_bit("done_o", done_o, 1'b0);
            check_burst("burst_o", burst_o, exp_q[i]);
            // second burst is not the last one here, so this strobe is dropped
            if (i == 1 && n >= 3) begin
                junk.length   = idma_pkg::len_t'($urandom_range(1, 64));
                junk.src_addr = $urandom;
                junk.dst_addr = $urandom;
                junk.src_opt  = idma_pkg::idma_side_opt_t'(5'($urandom));
                junk.dst_opt  = idma_pkg::idma_side_opt_t'(5'($urandom));
                req_valid_i   = 1'b1;
                req_i         = junk;
            end else begin
                req_valid_i = 1'b0;
                req_i       = '0;
            end
            step_cycle();
        end
        req_valid_i = 1'b0;
        req_i       = '0;
        check_bit("burst_valid_o", burst_valid_o, 1'b0);
        check_bit("busy_o", busy_o, 1'b0);
        wait_done(latency);
        if (timed_out) begin
            return;
        end
        if (latency != 0) begin
            errors++;
            $display("done_o came %0d cycles after the expected cycle", latency);
        end
        check_count("num_bursts_o", num_bursts_o, n);
        if (use_file) begin
            check_count("num_bursts_o", num_bursts_o, file_cnt);
        end
        step_cycle();
        // a single strobe and nothing left over
        check_bit("done_o", done_o, 1'b0);
        check_bit("burst_valid_o", burst_valid_o, 1'b0);
    endtask

    initial begin
        int                  fd;
        int                  code;
        int                  r;
        string               line;
        logic [31:0]         f_len;
        logic [31:0]         f_src;
        logic [31:0]         f_dst;
        logic [31:0]         f_sopt;
        logic [31:0]         f_dopt;
        logic [31:0]         f_cnt;
        idma_pkg::idma_req_t req;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        timed_out   = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        void'($urandom(SEED));
        repeat (10) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        // quiet outputs with no request
        repeat (20) begin
            check_bit("burst_valid_o", burst_valid_o, 1'b0);
            check_bit("busy_o", busy_o, 1'b0);
            check_bit("done_o", done_o, 1'b0);
            step_cycle();
        end
        // directed requests
        fd = $fopen("idma_legalizer_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open idma_legalizer_tests.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h",
                                   f_len, f_src, f_dst, f_sopt, f_dopt, f_cnt);
                    if (code == 6) begin
                        req.length   = f_len;
                        req.src_addr = f_src;
                        req.dst_addr = f_dst;
                        req.src_opt  = idma_pkg::idma_side_opt_t'(f_sopt[4:0]);
                        req.dst_opt  = idma_pkg::idma_side_opt_t'(f_dopt[4:0]);
                        run_request(req, idma_pkg::burst_cnt_t'(f_cnt), 1'b1);
                    end else begin
                        errors++;
                        $display("test file line could not be read: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        // random requests with some of zero length
        for (r = 0; r < 200 && !timed_out; r++) begin
            if ($urandom_range(0, 19) == 0) begin
                req.length = '0;
            end else begin
                req.length = idma_pkg::len_t'($urandom_range(1, 600));
            end
            req.src_addr = $urandom;
            req.dst_addr = $urandom;
            req.src_opt  = idma_pkg::idma_side_opt_t'(5'($urandom));
            req.dst_opt  = idma_pkg::idma_side_opt_t'(5'($urandom));
            run_request(req, '0, 1'b0);
        end
        step_cycle();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== idma_legalizer_top.f ====
idma_pkg.sv
idma_legalizer_page_splitter.sv
idma_legalizer.sv
idma_transfer_tracker.sv
idma_legalizer_top.sv
tb_idma_legalizer_top.sv

// ==== idma_legalizer_tests.txt ====
# length src_addr dst_addr src_opt dst_opt bursts, all hex
# opt is {not_bursting, reduce_len, max_llen[2:0]}
10 1000 2000 10 10 4
f 1001 2001 10 10 4
9 1003 2000 10 00 3
10 0 2 00 10 5
1 7 ff 10 10 1
0 1000 2000 10 10 0
400 0 0 00 00 1
800 200 0 00 00 4
1000 0 0 00 00 4
10 0 0 08 08 4
80 0 10 0b 00 4
100 1f0 0 0f 0c 5
20 4 0 09 0a 6
3000 100 0 00 00 18
6 ffe 1ffe 10 10 2
5 fffffffe 0 10 00 2
0 123 456 00 00 0
401 0 0 00 00 2
8 0 0 1f 00 2
100 0 40 0d 0d 4
3 1 2 10 10 2
300 80 80 0e 00 4
20 0 3 00 10 9
2 3ff 7ff 00 00 2
1000 0 0 0f 0f 8
fff 1 1 10 08 400
40 10 20 0a 0b 4
0 0 0 0f 0f 0
